// ==== hw/atomics_settings.svh ====
`ifndef ATOMICS_SETTINGS_SVH
`define ATOMICS_SETTINGS_SVH

// receivers are split into an even and an odd half, so keep this even
`define ATOM_N_RECEIVERS 4
`define ATOM_RCV_W 2

`define ATOM_DATA_W 32
`define ATOM_WORD_ADDR_W 16

// four words per line
`define ATOM_LINE_WORDS_W 2

// idle cycles before write-back is 2**width
`define ATOM_FLUSH_TIMER_W 3

`endif

// ==== hw/atomics_pkg.sv ====
`include "atomics_settings.svh"

package atomics_pkg;

   typedef enum logic {
      op_add,
      op_max
   } atomic_op_e;

   typedef enum logic [2:0] {
      unit_idle,
      listening,
      latch_line,
      select_word,
      functioning
   } atomic_state_e;

   // one request as a receiver presents it
   typedef struct packed {
      atomic_op_e                   op;
      logic [`ATOM_WORD_ADDR_W-1:0] addr;
      logic [`ATOM_DATA_W-1:0]      data;
   } atomic_rqst_t;

endpackage

// ==== hw/gmem_pkg.sv ====
`include "atomics_settings.svh"

package gmem_pkg;

   // line snooped from the read-data bus
   typedef struct packed {
      logic                                             valid;
      logic [`ATOM_WORD_ADDR_W-`ATOM_LINE_WORDS_W-1:0]  line_addr;
      logic [(`ATOM_DATA_W << `ATOM_LINE_WORDS_W)-1:0]  data;
   } gmem_line_t;

   typedef struct packed {
      logic [`ATOM_WORD_ADDR_W-1:0] addr;
      logic [`ATOM_DATA_W-1:0]      data;
   } flush_wr_t;

   typedef enum logic [1:0] {
      flush_idle,
      dirty,
      flushing,
      wait_ack
   } flush_state_e;

endpackage

// ==== hw/atomic_rqst_arbiter.sv ====
`timescale 1ns/1ns
`include "atomics_settings.svh"

module atomic_rqst_arbiter (
   input  logic                                              clk,
   input  logic                                              nrst,
   input  atomics_pkg::atomic_rqst_t [`ATOM_N_RECEIVERS-1:0] rcv_rqst,
   input  logic [`ATOM_N_RECEIVERS-1:0]                      rcv_rqst_v,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_ack,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_must_read,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_retire,
   output logic [`ATOM_DATA_W-1:0]                           atomic_rd_data,
   input  logic                                              add_addr_v,
   input  logic                                              max_addr_v,
   input  logic [`ATOM_WORD_ADDR_W-1:0]                      add_addr,
   input  logic [`ATOM_WORD_ADDR_W-1:0]                      max_addr,
   input  logic [`ATOM_DATA_W-1:0]                           add_value,
   input  logic [`ATOM_DATA_W-1:0]                           max_value,
   input  logic                                              line_loaded,
   output logic                                              add_start,
   output logic                                              max_start,
   output logic [`ATOM_WORD_ADDR_W-1:0]                      start_addr,
   output logic                                              add_exec,
   output logic                                              max_exec,
   output logic [`ATOM_DATA_W-1:0]                           exec_val
);

   logic                          half;
   logic                          pick_v;
   logic [`ATOM_RCV_W-1:0]        pick_idx;
   logic                          chk;
   logic                          chk_d;
   logic [`ATOM_RCV_W-1:0]        sel_idx;
   logic [`ATOM_RCV_W-1:0]        sel_idx_d;
   atomics_pkg::atomic_rqst_t     rqst;
   logic                          hit;
   logic                          reading;
   logic                          add_exec_d;
   logic [`ATOM_DATA_W-1:0]       add_value_d;
   logic [`ATOM_DATA_W-1:0]       max_value_d;

   // lowest requesting index in the current half
   always_comb begin
      pick_v = 1'b0;
      pick_idx = '0;
      for (int i = `ATOM_N_RECEIVERS/2-1; i >= 0; i--) begin
         if (rcv_rqst_v[2*i+half]) begin
            pick_v = 1'b1;
            pick_idx = `ATOM_RCV_W'(2*i+half);
         end
      end
   end

   assign hit = (rqst.op == atomics_pkg::op_add) ?
                (add_addr_v && add_addr == rqst.addr) :
                (max_addr_v && max_addr == rqst.addr);

   always_ff @(posedge clk) begin
      if (!nrst) begin
         half <= 1'b0;
         chk <= 1'b0;
         chk_d <= 1'b0;
         reading <= 1'b0;
         rcv_ack <= '0;
         rcv_must_read <= '0;
         rcv_retire <= '0;
         add_start <= 1'b0;
         max_start <= 1'b0;
         add_exec <= 1'b0;
         max_exec <= 1'b0;
         add_exec_d <= 1'b0;
      end else begin
         half <= ~half;
         rcv_ack <= '0;
         if (pick_v) begin
            rcv_ack[pick_idx] <= 1'b1;
         end
         chk <= pick_v;
         chk_d <= chk;

         rcv_must_read <= '0;
         rcv_retire <= '0;
         add_start <= 1'b0;
         max_start <= 1'b0;
         add_exec <= 1'b0;
         max_exec <= 1'b0;
         if (line_loaded) begin
            reading <= 1'b0;
         end
         // a miss while a line read is pending gets neither answer
         if (chk_d) begin
            if (hit) begin
               rcv_retire[sel_idx_d] <= 1'b1;
               add_exec <= (rqst.op == atomics_pkg::op_add);
               max_exec <= (rqst.op == atomics_pkg::op_max);
            end else if (!reading) begin
               rcv_must_read[sel_idx_d] <= 1'b1;
               reading <= 1'b1;
               add_start <= (rqst.op == atomics_pkg::op_add);
               max_start <= (rqst.op == atomics_pkg::op_max);
            end
         end
         add_exec_d <= add_exec;
      end
   end

   always_ff @(posedge clk) begin
      sel_idx <= pick_idx;
      sel_idx_d <= sel_idx;
      rqst <= rcv_rqst[sel_idx];
      start_addr <= rqst.addr;
      exec_val <= rqst.data;
      // value one cycle back is the word before the exec
      add_value_d <= add_value;
      max_value_d <= max_value;
      atomic_rd_data <= add_exec_d ? add_value_d : max_value_d;
   end

endmodule

// ==== hw/atomic_unit.sv ====
`timescale 1ns/1ns
`include "atomics_settings.svh"

module atomic_unit #(
   parameter atomics_pkg::atomic_op_e OP = atomics_pkg::op_add
) (
   input  logic                          clk,
   input  logic                          nrst,
   input  logic                          start,
   input  logic [`ATOM_WORD_ADDR_W-1:0]  start_addr,
   input  logic                          exec,
   input  logic [`ATOM_DATA_W-1:0]       exec_val,
   input  gmem_pkg::gmem_line_t          gmem_rd,
   input  logic                          finish,
   output logic                          addr_v,
   output logic [`ATOM_WORD_ADDR_W-1:0]  addr,
   output logic [`ATOM_DATA_W-1:0]       value,
   output logic                          line_loaded
);

   atomics_pkg::atomic_state_e                      state;
   atomics_pkg::atomic_state_e                      state_n;
   gmem_pkg::gmem_line_t                            snoop_q;
   logic [(`ATOM_DATA_W << `ATOM_LINE_WORDS_W)-1:0] line_q;
   logic                                            line_hit;
   logic [`ATOM_DATA_W-1:0]                         word;
   logic [`ATOM_DATA_W-1:0]                         result;

   assign line_hit = snoop_q.valid &&
                     snoop_q.line_addr == addr[`ATOM_WORD_ADDR_W-1:`ATOM_LINE_WORDS_W];
   assign word = line_q[addr[`ATOM_LINE_WORDS_W-1:0]*`ATOM_DATA_W +: `ATOM_DATA_W];

   // wrapping add or signed max
   always_comb begin
      if (OP == atomics_pkg::op_add) begin
         result = value + exec_val;
      end else if ($signed(exec_val) > $signed(value)) begin
         result = exec_val;
      end else begin
         result = value;
      end
   end

   always_comb begin
      state_n = state;
      case (state)
         atomics_pkg::unit_idle: begin
            if (start) begin
               state_n = atomics_pkg::listening;
            end
         end
         atomics_pkg::listening: begin
            if (line_hit) begin
               state_n = atomics_pkg::latch_line;
            end
         end
         atomics_pkg::latch_line: state_n = atomics_pkg::select_word;
         atomics_pkg::select_word: state_n = atomics_pkg::functioning;
         default: state_n = state;
      endcase
      if (finish) begin
         state_n = atomics_pkg::unit_idle;
      end
   end

   always_ff @(posedge clk) begin
      if (!nrst) begin
         state <= atomics_pkg::unit_idle;
         addr_v <= 1'b0;
         line_loaded <= 1'b0;
      end else begin
         state <= state_n;
         addr_v <= (state_n == atomics_pkg::functioning);
         line_loaded <= (state == atomics_pkg::select_word) &&
                        (state_n == atomics_pkg::functioning);
      end
   end

   always_ff @(posedge clk) begin
      snoop_q <= gmem_rd;
      if (state == atomics_pkg::unit_idle && start) begin
         addr <= start_addr;
      end
      if (state == atomics_pkg::listening && line_hit) begin
         line_q <= snoop_q.data;
      end
      if (state == atomics_pkg::select_word) begin
         value <= word;
      end else if (state == atomics_pkg::functioning && exec) begin
         value <= result;
      end
   end

endmodule

// ==== hw/atomic_flush_ctrl.sv ====
`timescale 1ns/1ns
`include "atomics_settings.svh"

module atomic_flush_ctrl (
   input  logic                          clk,
   input  logic                          nrst,
   input  logic                          add_exec,
   input  logic                          max_exec,
   input  logic [`ATOM_WORD_ADDR_W-1:0]  add_addr,
   input  logic [`ATOM_WORD_ADDR_W-1:0]  max_addr,
   input  logic [`ATOM_DATA_W-1:0]       add_value,
   input  logic [`ATOM_DATA_W-1:0]       max_value,
   output logic                          flush_v,
   output gmem_pkg::flush_wr_t           flush_wr,
   input  logic                          flush_ack,
   output logic                          atomic_can_finish
);

   logic [1:0] exec;
   logic [1:0] in_flush;
   logic [1:0] in_idle;
   logic [1:0] grant;
   logic       sel;
   logic       done;

   // index 0 follows the add unit, index 1 the max unit
   assign exec = {max_exec, add_exec};
   assign grant = flush_v ? 2'b00 : {in_flush[1] & ~in_flush[0], in_flush[0]};
   assign done = flush_v & flush_ack;
   assign atomic_can_finish = &in_idle;

   for (genvar i = 0; i < 2; i++) begin : g_mach
      gmem_pkg::flush_state_e          st;
      logic [`ATOM_FLUSH_TIMER_W-1:0]  timer;
      logic                            again;

      assign in_flush[i] = (st == gmem_pkg::flushing);
      assign in_idle[i] = (st == gmem_pkg::flush_idle);

      always_ff @(posedge clk) begin
         if (!nrst) begin
            st <= gmem_pkg::flush_idle;
            timer <= '0;
            again <= 1'b0;
         end else begin
            case (st)
               gmem_pkg::flush_idle: begin
                  timer <= '0;
                  if (exec[i] || again) begin
                     st <= gmem_pkg::dirty;
                  end
               end
               gmem_pkg::dirty: begin
                  if (exec[i]) begin
                     timer <= '0;
                  end else if (timer == '1) begin
                     st <= gmem_pkg::flushing;
                     again <= 1'b0;
                  end else begin
                     timer <= timer + 1'b1;
                  end
               end
               gmem_pkg::flushing: begin
                  if (exec[i]) begin
                     again <= 1'b1;
                  end
                  if (grant[i]) begin
                     st <= gmem_pkg::wait_ack;
                  end
               end
               default: begin
                  // value sent may already be stale
                  if (exec[i]) begin
                     again <= 1'b1;
                  end
                  if (done && sel == 1'(i)) begin
                     st <= gmem_pkg::flush_idle;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!nrst) begin
         flush_v <= 1'b0;
         sel <= 1'b0;
      end else if (!flush_v) begin
         if (|in_flush) begin
            flush_v <= 1'b1;
            sel <= ~in_flush[0];
         end
      end else if (flush_ack) begin
         flush_v <= 1'b0;
      end
   end

   // held while flush_v is up
   always_ff @(posedge clk) begin
      if (!flush_v) begin
         flush_wr.addr <= in_flush[0] ? add_addr : max_addr;
         flush_wr.data <= in_flush[0] ? add_value : max_value;
      end
   end

endmodule

// ==== hw/gmem_atomics.sv ====
`timescale 1ns/1ns
`include "atomics_settings.svh"

module gmem_atomics (
   input  logic                                              clk,
   input  logic                                              nrst,
   input  atomics_pkg::atomic_rqst_t [`ATOM_N_RECEIVERS-1:0] rcv_rqst,
   input  logic [`ATOM_N_RECEIVERS-1:0]                      rcv_rqst_v,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_ack,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_must_read,
   output logic [`ATOM_N_RECEIVERS-1:0]                      rcv_retire,
   output logic [`ATOM_DATA_W-1:0]                           atomic_rd_data,
   input  gmem_pkg::gmem_line_t                              gmem_rd,
   output logic                                              flush_v,
   output gmem_pkg::flush_wr_t                               flush_wr,
   input  logic                                              flush_ack,
   input  logic                                              finish,
   output logic                                              atomic_can_finish
);

   logic                          add_start;
   logic                          max_start;
   logic [`ATOM_WORD_ADDR_W-1:0]  start_addr;
   logic                          add_exec;
   logic                          max_exec;
   logic [`ATOM_DATA_W-1:0]       exec_val;
   logic                          add_addr_v;
   logic                          max_addr_v;
   logic [`ATOM_WORD_ADDR_W-1:0]  add_addr;
   logic [`ATOM_WORD_ADDR_W-1:0]  max_addr;
   logic [`ATOM_DATA_W-1:0]       add_value;
   logic [`ATOM_DATA_W-1:0]       max_value;
   logic                          add_loaded;
   logic                          max_loaded;

   atomic_rqst_arbiter i_arbiter (
      .clk            (clk),
      .nrst           (nrst),
      .rcv_rqst       (rcv_rqst),
      .rcv_rqst_v     (rcv_rqst_v),
      .rcv_ack        (rcv_ack),
      .rcv_must_read  (rcv_must_read),
      .rcv_retire     (rcv_retire),
      .atomic_rd_data (atomic_rd_data),
      .add_addr_v     (add_addr_v),
      .max_addr_v     (max_addr_v),
      .add_addr       (add_addr),
      .max_addr       (max_addr),
      .add_value      (add_value),
      .max_value      (max_value),
      .line_loaded    (add_loaded | max_loaded),
      .add_start      (add_start),
      .max_start      (max_start),
      .start_addr     (start_addr),
      .add_exec       (add_exec),
      .max_exec       (max_exec),
      .exec_val       (exec_val)
   );

   atomic_unit #(.OP(atomics_pkg::op_add)) add_unit (
      .clk         (clk),
      .nrst        (nrst),
      .start       (add_start),
      .start_addr  (start_addr),
      .exec        (add_exec),
      .exec_val    (exec_val),
      .gmem_rd     (gmem_rd),
      .finish      (finish),
      .addr_v      (add_addr_v),
      .addr        (add_addr),
      .value       (add_value),
      .line_loaded (add_loaded)
   );

   atomic_unit #(.OP(atomics_pkg::op_max)) max_unit (
      .clk         (clk),
      .nrst        (nrst),
      .start       (max_start),
      .start_addr  (start_addr),
      .exec        (max_exec),
      .exec_val    (exec_val),
      .gmem_rd     (gmem_rd),
      .finish      (finish),
      .addr_v      (max_addr_v),
      .addr        (max_addr),
      .value       (max_value),
      .line_loaded (max_loaded)
   );

   atomic_flush_ctrl i_flush_ctrl (
      .clk               (clk),
      .nrst              (nrst),
      .add_exec          (add_exec),
      .max_exec          (max_exec),
      .add_addr          (add_addr),
      .max_addr          (max_addr),
      .add_value         (add_value),
      .max_value         (max_value),
      .flush_v           (flush_v),
      .flush_wr          (flush_wr),
      .flush_ack         (flush_ack),
      .atomic_can_finish (atomic_can_finish)
   );

endmodule

// ==== test/tb_gmem_atomics.sv ====
`timescale 1ns/1ns
`include "atomics_settings.svh"

module tb_gmem_atomics;

   logic                                              clk;
   logic                                              nrst;
   atomics_pkg::atomic_rqst_t [`ATOM_N_RECEIVERS-1:0] rcv_rqst;
   logic [`ATOM_N_RECEIVERS-1:0]                      rcv_rqst_v;
   logic [`ATOM_N_RECEIVERS-1:0]                      rcv_ack;
   logic [`ATOM_N_RECEIVERS-1:0]                      rcv_must_read;
   logic [`ATOM_N_RECEIVERS-1:0]                      rcv_retire;
   logic [`ATOM_DATA_W-1:0]                           atomic_rd_data;
   gmem_pkg::gmem_line_t                              gmem_rd;
   logic                                              flush_v;
   gmem_pkg::flush_wr_t                               flush_wr;
   logic                                              flush_ack;
   logic                                              finish;
   logic                                              atomic_can_finish;

   logic [`ATOM_DATA_W-1:0] mem [0:(1<<`ATOM_WORD_ADDR_W)-1];
   int errors = 0;

   gmem_atomics i_gmem_atomics (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // one receiver requests, waits for ack, then sees retire, must_read or refusal
   task automatic do_request(input int idx, input logic op, input logic [15:0] addr,
         input logic [31:0] data, output logic [31:0] rd, output logic saw_mr,
         output logic ok);
      int tries;
      int n;
      logic done;
      saw_mr = 1'b0;
      ok = 1'b0;
      rd = '0;
      done = 1'b0;
      tries = 0;
      rcv_rqst[idx].op = atomics_pkg::atomic_op_e'(op);
      rcv_rqst[idx].addr = addr;
      rcv_rqst[idx].data = data;
      while (!done && tries < 200) begin
         rcv_rqst_v[idx] = 1'b1;
         n = 0;
         do begin
            @(posedge clk);
            #2;
            n++;
         end while (!rcv_ack[idx] && n < 200);
         rcv_rqst_v[idx] = 1'b0;
         if (!rcv_ack[idx]) begin
            $display("receiver %0d never got an ack", idx);
            tries = 200;
         end else begin
            repeat (2) begin
               @(posedge clk);
               #2;
            end
            if (rcv_retire[idx]) begin
               repeat (2) begin
                  @(posedge clk);
                  #2;
               end
               rd = atomic_rd_data;
               ok = 1'b1;
               done = 1'b1;
            end else if (rcv_must_read[idx]) begin
               saw_mr = 1'b1;
            end
            tries++;
         end
      end
   endtask

   // memory read path answering rcv_must_read with one line
   initial begin : line_model
      int line_wait;
      logic [`ATOM_WORD_ADDR_W-`ATOM_LINE_WORDS_W-1:0] pend;
      line_wait = 0;
      pend = '0;
      forever begin
         @(posedge clk);
         #2;
         gmem_rd.valid = 1'b0;
         if (line_wait > 0) begin
            line_wait--;
            if (line_wait == 0) begin
               gmem_rd.valid = 1'b1;
               gmem_rd.line_addr = pend;
               for (int w = 0; w < (1 << `ATOM_LINE_WORDS_W); w++) begin
                  gmem_rd.data[w*`ATOM_DATA_W +: `ATOM_DATA_W] = mem[{pend, 2'(w)}];
               end
            end
         end
         for (int i = 0; i < `ATOM_N_RECEIVERS; i++) begin
            if (rcv_must_read[i]) begin
               pend = rcv_rqst[i].addr[`ATOM_WORD_ADDR_W-1:`ATOM_LINE_WORDS_W];
               line_wait = $urandom % 3 + 1;
            end
         end
      end
   end

   // write-back port with random ack delay
   initial begin : flush_model
      int ack_wait;
      logic busy;
      gmem_pkg::flush_wr_t held;
      busy = 1'b0;
      ack_wait = 0;
      held = '0;
      forever begin
         @(posedge clk);
         #2;
         flush_ack = 1'b0;
         if (!flush_v) begin
            busy = 1'b0;
         end else begin
            if (!busy) begin
               held = flush_wr;
               busy = 1'b1;
               ack_wait = $urandom % 6;
            end else begin
               assert (flush_wr == held) else begin
                  $display("Fail flush_wr: expected %h, got %h", held, flush_wr);
                  errors++;
               end
            end
            if (ack_wait == 0) begin
               flush_ack = 1'b1;
               mem[held.addr] = held.data;
            end else begin
               ack_wait--;
            end
         end
      end
   end

   initial begin
      int fd;
      int code;
      int test_no;
      int cmd;
      int rcv;
      int op;
      int mr;
      int n;
      int cur_test;
      int tests_run;
      int tests_failed;
      int err_at_start;
      logic [15:0] addr;
      logic [31:0] operand;
      logic [31:0] expect_v;
      logic [31:0] rd0;
      logic [31:0] rd1;
      logic saw0;
      logic saw1;
      logic ok0;
      logic ok1;
      string line;

      void'($urandom(86598));
      nrst = 1'b0;
      rcv_rqst = '0;
      rcv_rqst_v = '0;
      gmem_rd = '0;
      flush_ack = 1'b0;
      finish = 1'b0;
      cur_test = 0;
      tests_run = 0;
      tests_failed = 0;
      err_at_start = 0;
      for (int a = 0; a < (1 << `ATOM_WORD_ADDR_W); a++) begin
         mem[a] = {16'(a) ^ 16'hc3a5, 16'(a)};
      end
      repeat (8) @(posedge clk);
      #2;
      nrst = 1'b1;

      fd = $fopen("test/atomics_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the test data file");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
               code = $sscanf(line, "%d %d %d %d %h %h %h %d", test_no, cmd, rcv, op,
                              addr, operand, expect_v, mr);
               if (test_no != cur_test) begin
                  if (cur_test != 0) begin
                     tests_run++;
                     if (errors != err_at_start) begin
                        tests_failed++;
                     end
                     $display("test %0d %s", cur_test, (errors == err_at_start) ? "ok" : "bad");
                  end
                  cur_test = test_no;
                  err_at_start = errors;
               end
               case (cmd)
                  0: begin
                     do_request(rcv, op[0], addr, operand, rd0, saw0, ok0);
                     assert (ok0) else begin
                        $display("test %0d: request of receiver %0d never retired", test_no, rcv);
                        errors++;
                     end
                     assert (saw0 == mr[0]) else begin
                        $display("Fail rcv_must_read: expected %h, got %h", mr[0], saw0);
                        errors++;
                     end
                     assert (rd0 == expect_v) else begin
                        $display("Fail atomic_rd_data: expected %h, got %h", expect_v, rd0);
                        errors++;
                     end
                  end
                  1: begin
                     n = 0;
                     do begin
                        @(posedge clk);
                        #2;
                        n++;
                     end while (!atomic_can_finish && n < 200);
                     assert (atomic_can_finish) else begin
                        $display("test %0d: write-back never completed", test_no);
                        errors++;
                     end
                     assert (mem[addr] == expect_v) else begin
                        $display("Fail mem[%h]: expected %h, got %h", addr, expect_v, mem[addr]);
                        errors++;
                     end
                  end
                  2: begin
                     finish = 1'b1;
                     @(posedge clk);
                     #2;
                     finish = 1'b0;
                  end
                  3: begin
                     fork
                        do_request(rcv, op[0], addr, operand, rd0, saw0, ok0);
                        do_request(rcv + 1, op[0], addr, operand, rd1, saw1, ok1);
                     join
                     assert (ok0 && ok1) else begin
                        $display("test %0d: one of the paired requests never retired", test_no);
                        errors++;
                     end
                     assert (saw0 == mr[0] && saw1 == mr[0]) else begin
                        $display("Fail rcv_must_read pair: expected %h, got %h/%h",
                                 mr[0], saw0, saw1);
                        errors++;
                     end
                     // running sums in either order
                     assert ((rd0 == expect_v && rd1 == expect_v + operand) ||
                             (rd1 == expect_v && rd0 == expect_v + operand)) else begin
                        $display("Fail atomic_rd_data pair: expected %h/%h, got %h/%h",
                                 expect_v, expect_v + operand, rd0, rd1);
                        errors++;
                     end
                  end
                  default: begin
                     assert (atomic_can_finish == expect_v[0]) else begin
                        $display("Fail atomic_can_finish: expected %h, got %h",
                                 expect_v[0], atomic_can_finish);
                        errors++;
                     end
                  end
               endcase
            end
         end
         $fclose(fd);
         if (cur_test != 0) begin
            tests_run++;
            if (errors != err_at_start) begin
               tests_failed++;
            end
            $display("test %0d %s", cur_test, (errors == err_at_start) ? "ok" : "bad");
         end
      end
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== test/atomics_tests.txt ====
# test cmd rcv op addr operand expect must_read (hex for addr, operand, expect)
# cmd 0 request, 1 write-back check, 2 finish, 3 pair rcv and rcv+1, 4 can_finish check
1 0 0 0 0010 00000005 c3b50010 1
2 0 1 0 0010 7fffffff c3b50015 0
2 0 1 0 0010 40000000 43b50014 0
2 0 1 0 0010 bc4affec 83b50014 0
2 0 1 0 0010 00000001 40000000 0
3 0 2 1 0023 80000000 c3860023 1
3 0 2 1 0023 fffffff0 c3860023 0
3 0 2 1 0023 00000005 fffffff0 0
3 0 2 1 0023 ffffffff 00000005 0
3 0 2 1 0023 00000100 00000005 0
4 1 0 0 0010 00000000 40000001 0
4 1 0 1 0023 00000000 00000100 0
5 0 3 0 0010 00000010 40000001 0
5 4 0 0 0000 00000000 00000000 0
5 1 0 0 0010 00000000 40000011 0
5 2 0 0 0000 00000000 00000000 0
5 0 0 0 0010 00000002 40000011 1
6 3 0 0 0010 00000100 40000013 0
6 1 0 0 0010 00000000 40000213 0

// ==== filelist.f ====
+incdir+hw
hw/atomics_pkg.sv
hw/gmem_pkg.sv
hw/atomic_rqst_arbiter.sv
hw/atomic_unit.sv
hw/atomic_flush_ctrl.sv
hw/gmem_atomics.sv
test/tb_gmem_atomics.sv

// ==== Bender.yml ====
package:
  name: gmem_atomics

sources:
  - include_dirs:
      - hw
    files:
      - hw/atomics_pkg.sv
      - hw/gmem_pkg.sv
      - hw/atomic_rqst_arbiter.sv
      - hw/atomic_unit.sv
      - hw/atomic_flush_ctrl.sv
      - hw/gmem_atomics.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_gmem_atomics.sv
